/* filelist.f */
hdl/dws_pkg.sv
hdl/dws_ar_dispatch.sv
hdl/dws_lane_order.sv
hdl/dws_read_lane.sv
hdl/dws_r_arbiter.sv
hdl/dws_read_top.sv
test/dws_tb.sv

/* test/dws_tb.sv */
// ##########################################################
// Testbench of the read downsizer. The memory model returns
// bursts in issue order with random gaps; memory byte k
// holds k[7:0] ^ k[15:8]. Needs concurrent assertion support.
// ##########################################################

`timescale 1ns/1ps

module dws_tb import dws_pkg::*; ();

  logic                       clk_i;
  logic                       rst_ni;
  logic [AddrWidth-1:0]       ar_addr_i;
  logic [IdWidth-1:0]         ar_id_i;
  logic [LenWidth-1:0]        ar_len_i;
  logic [SizeWidth-1:0]       ar_size_i;
  logic                       ar_valid_i;
  logic                       ar_ready_o;
  logic [AddrWidth-1:0]       nar_addr_o;
  logic [IdWidth-1:0]         nar_id_o;
  logic [LenWidth-1:0]        nar_len_o;
  logic [SizeWidth-1:0]       nar_size_o;
  logic                       nar_valid_o;
  logic                       nar_ready_i;
  logic [NarrowDataWidth-1:0] nr_data_i;
  logic [IdWidth-1:0]         nr_id_i;
  logic                       nr_last_i;
  logic                       nr_valid_i;
  logic                       nr_ready_o;
  logic [WideDataWidth-1:0]   r_data_o;
  logic [IdWidth-1:0]         r_id_o;
  logic                       r_last_o;
  logic                       r_valid_o;
  logic                       r_ready_i;

  // Expected wide beats, one ring per ID
  logic [WideDataWidth-1:0] exp_data [2**IdWidth][256];
  logic [WideDataWidth-1:0] exp_mask [2**IdWidth][256];
  logic                     exp_last [2**IdWidth][256];
  logic [7:0]               wr_ptr [2**IdWidth];
  logic [7:0]               rd_ptr [2**IdWidth];
  logic [WideDataWidth-1:0] exp_word;
  logic [WideDataWidth-1:0] exp_bmask;
  logic                     exp_end;
  logic [AddrWidth-1:0]     exp_nar_addr;
  logic [IdWidth-1:0]       exp_nar_id;
  logic [LenWidth-1:0]      exp_nar_len;
  logic [SizeWidth-1:0]     exp_nar_size;

  int    total_tx;
  int    total_rx;
  int    errors;
  int    errs_before;
  int    tests_run;
  int    tests_failed;
  int    beat_idx;
  logic  stall_en;
  string test_name;

  // Bursts accepted by the memory model, oldest first
  logic [AddrWidth-1:0] burst_addr [$];
  logic [LenWidth-1:0]  burst_len [$];
  logic [SizeWidth-1:0] burst_size [$];
  logic [IdWidth-1:0]   burst_id [$];

  dws_read_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    // 20 ns period
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  function automatic logic [7:0] mem_byte(input logic [31:0] k);
    return k[7:0] ^ k[15:8];
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] a);
    logic [31:0] w;
    w = a & ~32'd3;
    return {mem_byte(w + 3), mem_byte(w + 2), mem_byte(w + 1), mem_byte(w)};
  endfunction

  // INCR address of beat idx
  function automatic logic [31:0] beat_addr(input logic [31:0] start,
                                            input logic [2:0] size, input int idx);
    logic [31:0] step;
    step = 32'd1 << size;
    if (idx == 0) begin
      return start;
    end
    return (start & ~(step - 1)) + 32'(idx) * step;
  endfunction

  task automatic report_err(input string what, input logic [63:0] exp,
                            input logic [63:0] act);
    errors++;
    $display("ERR %s %s: expected %0h actual %0h", test_name, what, exp, act);
  endtask

  task automatic note_failure(input string what);
    errors++;
    $display("Error in %s: %s", test_name, what);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    errs_before = errors;
  endtask

  task automatic finish_test();
    int n;
    n = errors - errs_before;
    tests_run++;
    if (n == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d error(s)", test_name, n);
    end
  endtask

  // Wide beats the requester must see, lanes below the address masked off
  task automatic expect_burst(input logic [31:0] addr, input logic [3:0] id,
                              input logic [7:0] len, input logic [2:0] size);
    logic [31:0] a;
    logic [31:0] base;
    logic [63:0] data;
    logic [63:0] mask;
    int          lo;
    int          hi;
    for (int i = 0; i <= int'(len); i++) begin
      a    = beat_addr(addr, size, i);
      base = a & ~((32'd1 << size) - 1);
      lo   = int'(a % 8);
      hi   = int'(base % 8) + (1 << size);
      data = '0;
      mask = '0;
      for (int b = lo; b < hi; b++) begin
        data[8*b +: 8] = mem_byte((a & ~32'd7) + 32'(b));
        mask[8*b +: 8] = 8'hff;
      end
      exp_data[id][wr_ptr[id]] = data;
      exp_mask[id][wr_ptr[id]] = mask;
      exp_last[id][wr_ptr[id]] = (i == int'(len));
      wr_ptr[id] = wr_ptr[id] + 1'b1;
      total_tx++;
    end
  endtask

  task automatic issue_read(input logic [31:0] addr, input logic [3:0] id,
                            input logic [7:0] len, input logic [2:0] size);
    int beats;
    expect_burst(addr, id, len, size);
    beats = (size == 3'd3) ? 2 * (int'(len) + 1) - int'(addr[2]) : int'(len) + 1;
    @(posedge clk_i);
    ar_addr_i  <= addr;
    ar_id_i    <= id;
    ar_len_i   <= len;
    ar_size_i  <= size;
    ar_valid_i <= 1'b1;
    do begin
      @(posedge clk_i);
    end while (!ar_ready_o);
    ar_valid_i   <= 1'b0;
    exp_nar_addr <= addr;
    exp_nar_id   <= id;
    exp_nar_len  <= 8'(beats - 1);
    exp_nar_size <= (size == 3'd3) ? 3'd2 : size;
  endtask

  task automatic wait_done();
    while (total_rx != total_tx) begin
      @(posedge clk_i);
    end
  endtask

  // Narrow memory, answers whole bursts in acceptance order
  always @(posedge clk_i) begin : narrow_mem
    logic took;
    if (rst_ni) begin
      if (nar_valid_o && nar_ready_i) begin
        burst_addr.push_back(nar_addr_o);
        burst_len.push_back(nar_len_o);
        burst_size.push_back(nar_size_o);
        burst_id.push_back(nar_id_o);
      end
      nar_ready_i <= ($urandom % 4) != 0;
      took = nr_valid_i && nr_ready_o;
      if (took && nr_last_i) begin
        burst_addr.delete(0);
        burst_len.delete(0);
        burst_size.delete(0);
        burst_id.delete(0);
        beat_idx = 0;
      end else if (took) begin
        beat_idx++;
      end
      if (!nr_valid_i || took) begin
        if (burst_addr.size() > 0 && ($urandom % 3) != 0) begin
          nr_data_i  <= read_word(beat_addr(burst_addr[0], burst_size[0], beat_idx));
          nr_id_i    <= burst_id[0];
          nr_last_i  <= (beat_idx == int'(burst_len[0]));
          nr_valid_i <= 1'b1;
        end else begin
          nr_valid_i <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk_i) begin : resp_monitor
    if (!rst_ni) begin
      for (int i = 0; i < 2**IdWidth; i++) begin
        rd_ptr[i] <= '0;
      end
      total_rx <= 0;
    end else begin
      if (r_valid_o && r_ready_i) begin
        rd_ptr[r_id_o] <= rd_ptr[r_id_o] + 1'b1;
        total_rx       <= total_rx + 1;
      end
      r_ready_i <= stall_en ? 1'($urandom % 2) : 1'b1;
    end
  end

  assign exp_word  = exp_data[r_id_o][rd_ptr[r_id_o]];
  assign exp_bmask = exp_mask[r_id_o][rd_ptr[r_id_o]];
  assign exp_end   = exp_last[r_id_o][rd_ptr[r_id_o]];

  a_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (!ar_ready_o && !r_valid_o && !nar_valid_o && !nr_ready_o))
    else note_failure("handshake output high during reset");

  a_nar_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (nar_valid_o && nar_ready_i) |-> (nar_addr_o == exp_nar_addr))
    else report_err("nar_addr", $sampled(exp_nar_addr), $sampled(nar_addr_o));

  a_nar_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (nar_valid_o && nar_ready_i) |-> (nar_id_o == exp_nar_id))
    else report_err("nar_id", $sampled(exp_nar_id), $sampled(nar_id_o));

  a_nar_len: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (nar_valid_o && nar_ready_i) |-> (nar_len_o == exp_nar_len))
    else report_err("nar_len", $sampled(exp_nar_len), $sampled(nar_len_o));

  a_nar_size: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (nar_valid_o && nar_ready_i) |-> (nar_size_o == exp_nar_size))
    else report_err("nar_size", $sampled(exp_nar_size), $sampled(nar_size_o));

  a_nar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (nar_valid_o && !nar_ready_i) |=> (nar_valid_o && $stable(nar_addr_o)))
    else note_failure("narrow address dropped or changed while stalled");

  a_r_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_o && r_ready_i) |-> (wr_ptr[r_id_o] != rd_ptr[r_id_o]))
    else note_failure("wide beat for an ID with nothing outstanding");

  a_r_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_o && r_ready_i) |-> ((r_data_o & exp_bmask) == exp_word))
    else report_err("r_data", $sampled(exp_word), $sampled(r_data_o & exp_bmask));

  a_r_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_o && r_ready_i) |-> (r_last_o == exp_end))
    else report_err("r_last", 64'($sampled(exp_end)), 64'($sampled(r_last_o)));

  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (r_valid_o && !r_ready_i) |=> (r_valid_o && $stable(r_data_o)
                                   && $stable(r_id_o) && $stable(r_last_o)))
    else note_failure("wide response dropped or changed while r_ready was low");

  // Budget grows with every issued wide beat
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 1000 + 200 * total_tx) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: responses stopped arriving after %0d cycles", cycles);
    $display("Test failures found");
    $finish;
  end

  initial begin : main
    logic [31:0] addr;
    logic [7:0]  len;
    void'($urandom(32'ha16));
    rst_ni      <= 1'b0;
    ar_addr_i   <= '0;
    ar_id_i     <= '0;
    ar_len_i    <= '0;
    ar_size_i   <= '0;
    ar_valid_i  <= 1'b0;
    nar_ready_i <= 1'b0;
    nr_data_i   <= '0;
    nr_id_i     <= '0;
    nr_last_i   <= 1'b0;
    nr_valid_i  <= 1'b0;
    r_ready_i   <= 1'b0;
    stall_en     = 1'b0;
    beat_idx     = 0;
    total_tx     = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    for (int i = 0; i < 2**IdWidth; i++) begin
      wr_ptr[i] = '0;
    end
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    start_test("reset_state");
    @(posedge clk_i);
    assert (!ar_ready_o && !r_valid_o && !nar_valid_o)
      else note_failure("handshake output high on the first clock after reset");
    @(posedge clk_i);
    assert (ar_ready_o === 1'b1) else report_err("ar_ready", 64'd1, 64'(ar_ready_o));
    finish_test();

    start_test("passthrough");
    for (int i = 0; i < 12; i++) begin
      issue_read($urandom, 4'($urandom), 8'($urandom % 16), 3'(i % 3));
      wait_done();
    end
    finish_test();

    start_test("aligned_downsize");
    for (int i = 0; i < 6; i++) begin
      len = (i == 0) ? 8'd0 : (i == 1) ? 8'd127 : 8'($urandom % 128);
      issue_read($urandom & ~32'd7, 4'($urandom), len, 3'd3);
      wait_done();
    end
    finish_test();

    start_test("unaligned_downsize");
    for (int i = 0; i < 6; i++) begin
      len  = (i == 0) ? 8'd0 : (i == 1) ? 8'd127 : 8'($urandom % 128);
      addr = ($urandom & ~32'd7) | 32'd4 | ($urandom % 4);
      issue_read(addr, 4'($urandom), len, 3'd3);
      wait_done();
    end
    finish_test();

    start_test("outstanding");
    stall_en = 1'b1;
    issue_read($urandom & ~32'd7, 4'd4, 8'($urandom % 32), 3'd3);
    issue_read($urandom, 4'd5, 8'($urandom % 16), 3'd1);
    issue_read($urandom | 32'd4, 4'd6, 8'($urandom % 32), 3'd3);
    issue_read($urandom, 4'd7, 8'($urandom % 16), 3'd2);
    wait_done();
    stall_en = 1'b0;
    finish_test();

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* hdl/dws_read_top.sv */
// ##########################################################
// Read path of a 64-to-32 bit downsizer. The narrow side
// must return bursts in the order they were issued; the
// returned narrow ID is not used for routing.
// ##########################################################

`timescale 1ns/1ps

module dws_read_top import dws_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Wide address channel
  input  logic [AddrWidth-1:0]       ar_addr_i,
  input  logic [IdWidth-1:0]         ar_id_i,
  input  logic [LenWidth-1:0]        ar_len_i,
  input  logic [SizeWidth-1:0]       ar_size_i,
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  // Narrow address channel
  output logic [AddrWidth-1:0]       nar_addr_o,
  output logic [IdWidth-1:0]         nar_id_o,
  output logic [LenWidth-1:0]        nar_len_o,
  output logic [SizeWidth-1:0]       nar_size_o,
  output logic                       nar_valid_o,
  input  logic                       nar_ready_i,
  // Narrow response channel
  input  logic [NarrowDataWidth-1:0] nr_data_i,
  input  logic [IdWidth-1:0]         nr_id_i,
  input  logic                       nr_last_i,
  input  logic                       nr_valid_i,
  output logic                       nr_ready_o,
  // Wide response channel
  output logic [WideDataWidth-1:0]   r_data_o,
  output logic [IdWidth-1:0]         r_id_o,
  output logic                       r_last_o,
  output logic                       r_valid_o,
  input  logic                       r_ready_i
);

  // Shared lane descriptor
  logic [AddrWidth-1:0] desc_addr;
  logic [IdWidth-1:0]   desc_id;
  logic [LenWidth-1:0]  desc_len;
  logic [SizeWidth-1:0] desc_size;
  logic                 desc_downsize;

  logic                    push;
  logic [LaneIdxWidth-1:0] push_lane;

  logic [NumLanes-1:0] lane_idle;
  logic [NumLanes-1:0] lane_load;
  logic [NumLanes-1:0] lane_nr_valid;
  logic [NumLanes-1:0] lane_nr_ready;
  logic [NumLanes-1:0] lane_valid;
  logic [NumLanes-1:0] lane_last;
  logic [NumLanes-1:0] lane_gnt;

  logic [NumLanes-1:0][WideDataWidth-1:0] lane_data;
  logic [NumLanes-1:0][IdWidth-1:0]       lane_id;

  dws_ar_dispatch i_dispatch (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ar_addr_i       (ar_addr_i),
    .ar_id_i         (ar_id_i),
    .ar_len_i        (ar_len_i),
    .ar_size_i       (ar_size_i),
    .ar_valid_i      (ar_valid_i),
    .ar_ready_o      (ar_ready_o),
    .lane_idle_i     (lane_idle),
    .nar_addr_o      (nar_addr_o),
    .nar_id_o        (nar_id_o),
    .nar_len_o       (nar_len_o),
    .nar_size_o      (nar_size_o),
    .nar_valid_o     (nar_valid_o),
    .nar_ready_i     (nar_ready_i),
    .lane_load_o     (lane_load),
    .desc_addr_o     (desc_addr),
    .desc_id_o       (desc_id),
    .desc_len_o      (desc_len),
    .desc_size_o     (desc_size),
    .desc_downsize_o (desc_downsize),
    .push_o          (push),
    .push_lane_o     (push_lane)
  );

  dws_lane_order i_order (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .push_i          (push),
    .push_lane_i     (push_lane),
    .nr_valid_i      (nr_valid_i),
    .nr_last_i       (nr_last_i),
    .nr_ready_o      (nr_ready_o),
    .lane_nr_valid_o (lane_nr_valid),
    .lane_nr_ready_i (lane_nr_ready)
  );

  for (genvar i = 0; i < NumLanes; i++) begin : gen_lane
    dws_read_lane i_lane (
      .clk_i           (clk_i),
      .rst_ni          (rst_ni),
      .load_i          (lane_load[i]),
      .desc_addr_i     (desc_addr),
      .desc_id_i       (desc_id),
      .desc_len_i      (desc_len),
      .desc_size_i     (desc_size),
      .desc_downsize_i (desc_downsize),
      .idle_o          (lane_idle[i]),
      .nr_valid_i      (lane_nr_valid[i]),
      .nr_data_i       (nr_data_i),
      .nr_last_i       (nr_last_i),
      .nr_ready_o      (lane_nr_ready[i]),
      .r_data_o        (lane_data[i]),
      .r_id_o          (lane_id[i]),
      .r_last_o        (lane_last[i]),
      .r_valid_o       (lane_valid[i]),
      .gnt_i           (lane_gnt[i])
    );
  end

  dws_r_arbiter i_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .lane_data_i  (lane_data),
    .lane_id_i    (lane_id),
    .lane_last_i  (lane_last),
    .lane_valid_i (lane_valid),
    .gnt_o        (lane_gnt),
    .r_data_o     (r_data_o),
    .r_id_o       (r_id_o),
    .r_last_o     (r_last_o),
    .r_valid_o    (r_valid_o),
    .r_ready_i    (r_ready_i)
  );

endmodule

/* hdl/dws_r_arbiter.sv */
// ##########################################################
// Round-robin merge of the lane outputs. A lane that was
// offered and stalled keeps the grant until it transfers.
// ##########################################################

`timescale 1ns/1ps

module dws_r_arbiter import dws_pkg::*; (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic [NumLanes-1:0][WideDataWidth-1:0] lane_data_i,
  input  logic [NumLanes-1:0][IdWidth-1:0]       lane_id_i,
  input  logic [NumLanes-1:0]                    lane_last_i,
  input  logic [NumLanes-1:0]                    lane_valid_i,
  output logic [NumLanes-1:0]                    gnt_o,
  output logic [WideDataWidth-1:0]               r_data_o,
  output logic [IdWidth-1:0]                     r_id_o,
  output logic                                   r_last_o,
  output logic                                   r_valid_o,
  input  logic                                   r_ready_i
);

  logic [LaneIdxWidth-1:0] ptr_q;
  logic                    lock_q;
  logic [LaneIdxWidth-1:0] lock_idx_q;
  logic [LaneIdxWidth-1:0] sel;

  always_comb begin : sel_search
    logic [LaneIdxWidth-1:0] idx;
    logic                    found;
    sel   = ptr_q;
    found = 1'b0;
    // First valid lane at or after the pointer
    for (int k = 0; k < NumLanes; k++) begin
      idx = ptr_q + LaneIdxWidth'(k);
      if (!found && lane_valid_i[idx]) begin
        sel   = idx;
        found = 1'b1;
      end
    end
    if (lock_q) begin
      sel = lock_idx_q;
    end
  end

  assign r_valid_o = lane_valid_i[sel];
  assign r_data_o  = lane_data_i[sel];
  assign r_id_o    = lane_id_i[sel];
  assign r_last_o  = lane_last_i[sel];

  always_comb begin
    gnt_o      = '0;
    gnt_o[sel] = r_valid_o && r_ready_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (r_valid_o && !r_ready_i) begin
      lock_q     <= 1'b1;
      lock_idx_q <= sel;
    end else if (r_valid_o) begin
      lock_q <= 1'b0;
      ptr_q  <= sel + 1'b1;
    end
  end

endmodule

/* hdl/dws_read_lane.sv */
// ##########################################################
// One outstanding read. Narrow beats are packed into wide
// beats; passthrough bursts give one wide beat per narrow
// beat. All bursts are treated as INCR.
// ##########################################################

`timescale 1ns/1ps

module dws_read_lane import dws_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       load_i,
  input  logic [AddrWidth-1:0]       desc_addr_i,
  input  logic [IdWidth-1:0]         desc_id_i,
  input  logic [LenWidth-1:0]        desc_len_i,
  input  logic [SizeWidth-1:0]       desc_size_i,
  input  logic                       desc_downsize_i,
  output logic                       idle_o,
  input  logic                       nr_valid_i,
  input  logic [NarrowDataWidth-1:0] nr_data_i,
  input  logic                       nr_last_i,
  output logic                       nr_ready_o,
  output logic [WideDataWidth-1:0]   r_data_o,
  output logic [IdWidth-1:0]         r_id_o,
  output logic                       r_last_o,
  output logic                       r_valid_o,
  input  logic                       gnt_i
);

  logic [1:0]                      state_q;
  logic                            valid_q;
  logic                            fill_q;
  logic [AddrWidth-1:0]            addr_q;
  logic [SizeWidth-1:0]            size_q;
  logic [IdWidth-1:0]              id_q;
  logic [LenWidth-1:0]             rem_q;
  logic                            last_q;
  wide_beat_u                      data_q;
  wide_beat_u                      beat_d;
  logic [$clog2(WideBytes)-1:0]    offset;
  logic [SizeWidth-1:0]            step;
  logic [AddrWidth-1:0]            size_mask;
  logic                            nr_hs;
  logic                            r_hs;
  logic                            final_beat;

  assign idle_o = (state_q == LaneIdle);

  // Output slot must be empty or draining this cycle
  assign nr_ready_o = !idle_o && (!valid_q || gnt_i);
  assign nr_hs      = nr_valid_i && nr_ready_o;
  assign r_hs       = valid_q && gnt_i;

  assign offset    = addr_q[$clog2(WideBytes)-1:0];
  assign step      = (state_q == LaneDown) ? NarrowSize : size_q;
  assign size_mask = (AddrWidth'(1) << step) - 1'b1;

  // Upper word filled or burst done
  assign final_beat = (state_q != LaneDown) || nr_last_i
                    || addr_q[$clog2(NarrowBytes)];

  always_comb begin
    beat_d = fill_q ? data_q : '0;
    if (state_q == LaneDown) begin
      beat_d.words[addr_q[$clog2(NarrowBytes)]] = nr_data_i;
    end else begin
      // Only the bytes of the current size container at or above the address
      for (int b = 0; b < WideBytes; b++) begin
        if ((b >= offset) && ((b >> size_q) == (offset >> size_q))) begin
          beat_d.bytes[b] = nr_data_i[8*(b % NarrowBytes) +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LaneIdle;
      valid_q <= 1'b0;
      fill_q  <= 1'b0;
    end else begin
      if (load_i) begin
        state_q <= desc_downsize_i ? LaneDown : LanePass;
      end else if (r_hs && last_q) begin
        state_q <= LaneIdle;
      end
      if (nr_hs) begin
        valid_q <= final_beat;
        fill_q  <= !final_beat;
      end else if (r_hs) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      addr_q <= desc_addr_i;
      size_q <= desc_size_i;
      id_q   <= desc_id_i;
      rem_q  <= desc_len_i;
    end else if (nr_hs) begin
      addr_q <= (addr_q & ~size_mask) + (size_mask + 1'b1);
      data_q <= beat_d;
      if (final_beat) begin
        last_q <= (rem_q == '0);
        rem_q  <= rem_q - 1'b1;
      end
    end
  end

  assign r_data_o  = data_q;
  assign r_id_o    = id_q;
  assign r_last_o  = last_q;
  assign r_valid_o = valid_q;

endmodule

/* hdl/dws_lane_order.sv */
// ##########################################################
// Lane indices in narrow issue order. Assumes the memory
// returns whole bursts in the order they were accepted.
// ##########################################################

`timescale 1ns/1ps

module dws_lane_order import dws_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    push_i,
  input  logic [LaneIdxWidth-1:0] push_lane_i,
  input  logic                    nr_valid_i,
  input  logic                    nr_last_i,
  output logic                    nr_ready_o,
  output logic [NumLanes-1:0]     lane_nr_valid_o,
  input  logic [NumLanes-1:0]     lane_nr_ready_i
);

  logic [NumLanes-1:0][LaneIdxWidth-1:0] mem_q;
  logic [LaneIdxWidth-1:0]               wr_q;
  logic [LaneIdxWidth-1:0]               rd_q;
  logic [LaneIdxWidth:0]                 cnt_q;
  logic [LaneIdxWidth-1:0]               head;
  logic                                  empty;
  logic                                  pop;

  assign head  = mem_q[rd_q];
  assign empty = (cnt_q == '0);

  // Steer the narrow handshake to the lane that owns the oldest burst
  assign nr_ready_o = !empty && lane_nr_ready_i[head];
  assign pop        = nr_valid_i && nr_ready_o && nr_last_i;

  always_comb begin
    for (int i = 0; i < NumLanes; i++) begin
      lane_nr_valid_o[i] = nr_valid_i && !empty && (head == LaneIdxWidth'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_q  <= '0;
      rd_q  <= '0;
      cnt_q <= '0;
    end else begin
      if (push_i) begin
        wr_q <= wr_q + 1'b1;
      end
      if (pop) begin
        rd_q <= rd_q + 1'b1;
      end
      // At most one entry per lane
      cnt_q <= cnt_q + (LaneIdxWidth+1)'(push_i) - (LaneIdxWidth+1)'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_q] <= push_lane_i;
    end
  end

endmodule

/* hdl/dws_ar_dispatch.sv */
// ##########################################################
// Takes one wide read address at a time and issues it as a
// narrow burst. Size 3 becomes size 2 with a recomputed
// length; len must stay at or below 127 for that case.
// ##########################################################

`timescale 1ns/1ps

module dws_ar_dispatch import dws_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [AddrWidth-1:0]     ar_addr_i,
  input  logic [IdWidth-1:0]       ar_id_i,
  input  logic [LenWidth-1:0]      ar_len_i,
  input  logic [SizeWidth-1:0]     ar_size_i,
  input  logic                     ar_valid_i,
  output logic                     ar_ready_o,
  input  logic [NumLanes-1:0]      lane_idle_i,
  output logic [AddrWidth-1:0]     nar_addr_o,
  output logic [IdWidth-1:0]       nar_id_o,
  output logic [LenWidth-1:0]      nar_len_o,
  output logic [SizeWidth-1:0]     nar_size_o,
  output logic                     nar_valid_o,
  input  logic                     nar_ready_i,
  output logic [NumLanes-1:0]      lane_load_o,
  output logic [AddrWidth-1:0]     desc_addr_o,
  output logic [IdWidth-1:0]       desc_id_o,
  output logic [LenWidth-1:0]      desc_len_o,
  output logic [SizeWidth-1:0]     desc_size_o,
  output logic                     desc_downsize_o,
  output logic                     push_o,
  output logic [LaneIdxWidth-1:0]  push_lane_o
);

  logic                    run_q;
  logic                    pend_q;
  logic [AddrWidth-1:0]    addr_q;
  logic [IdWidth-1:0]      id_q;
  logic [LenWidth-1:0]     len_q;
  logic [SizeWidth-1:0]    size_q;
  logic                    down_q;
  logic [LenWidth-1:0]     nar_len_q;
  logic                    ar_hs;
  logic                    nar_hs;
  logic                    downsize;
  logic [BeatCntWidth-1:0] beat_cnt;
  logic [LaneIdxWidth-1:0] free_lane;

  // One request in flight on the narrow address channel
  assign ar_ready_o = run_q && !pend_q && (|lane_idle_i);
  assign ar_hs      = ar_valid_i && ar_ready_o;
  assign nar_hs     = pend_q && nar_ready_i;

  assign downsize = ar_size_i > NarrowSize;

  // Two narrow beats per wide beat, one less if the start sits in the upper word
  assign beat_cnt = {ar_len_i, 1'b0} + BeatCntWidth'(2)
                  - BeatCntWidth'(ar_addr_i[$clog2(NarrowBytes)]);

  // Lowest index idle lane
  always_comb begin
    free_lane = '0;
    for (int i = NumLanes - 1; i >= 0; i--) begin
      if (lane_idle_i[i]) begin
        free_lane = LaneIdxWidth'(i);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < NumLanes; i++) begin
      lane_load_o[i] = nar_hs && (free_lane == LaneIdxWidth'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q  <= 1'b0;
      pend_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (ar_hs) begin
        pend_q <= 1'b1;
      end else if (nar_hs) begin
        pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      addr_q <= ar_addr_i;
      id_q   <= ar_id_i;
      len_q  <= ar_len_i;
      size_q <= ar_size_i;
      down_q <= downsize;
      // A count of 256 wraps to zero here, so the minus one lands on 255
      nar_len_q <= downsize ? beat_cnt[LenWidth-1:0] - 1'b1 : ar_len_i;
    end
  end

  assign nar_addr_o  = addr_q;
  assign nar_id_o    = id_q;
  assign nar_len_o   = nar_len_q;
  assign nar_size_o  = down_q ? NarrowSize : size_q;
  assign nar_valid_o = pend_q;

  assign desc_addr_o     = addr_q;
  assign desc_id_o       = id_q;
  assign desc_len_o      = len_q;
  assign desc_size_o     = size_q;
  assign desc_downsize_o = down_q;

  assign push_o      = nar_hs;
  assign push_lane_o = free_lane;

endmodule

/* hdl/dws_pkg.sv */
// ##########################################################
// Shared constants of the read downsizer, 64-bit wide side
// to 32-bit narrow side. Only INCR bursts are handled, and
// downsized reads must keep len at or below 127.
// ##########################################################

package dws_pkg;

  // Bus geometry
  localparam int AddrWidth       = 32;
  localparam int IdWidth         = 4;
  localparam int WideDataWidth   = 64;
  localparam int NarrowDataWidth = 32;
  localparam int WideBytes       = WideDataWidth / 8;
  localparam int NarrowBytes     = NarrowDataWidth / 8;

  // Outstanding transactions, one per lane
  localparam int NumLanes     = 4;
  localparam int LaneIdxWidth = 2;

  // AXI field widths
  localparam int LenWidth  = 8;
  localparam int SizeWidth = 3;
  localparam logic [SizeWidth-1:0] NarrowSize = 3'd2;

  // Narrow beat count of a downsized burst, up to 256
  localparam int BeatCntWidth = 9;

  // Lane FSM encodings
  localparam logic [1:0] LaneIdle = 2'd0;
  localparam logic [1:0] LanePass = 2'd1;
  localparam logic [1:0] LaneDown = 2'd2;

  // Wide data beat, seen as bytes or as narrow words
  typedef union packed {
    logic [WideBytes-1:0][7:0]                             bytes;
    logic [WideBytes/NarrowBytes-1:0][NarrowDataWidth-1:0] words;
  } wide_beat_u;

endpackage
